// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cp0_unit
FLIST     ?= cp0_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST)) cp0_defs.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# status comes from grep, so a missing pass line fails the target
run: compile
	./$(SIM) | tee /dev/stderr | grep -q '^TEST PASS$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== cp0_defs.svh ====
`ifndef CP0_DEFS_SVH
`define CP0_DEFS_SVH

`define CP0_REG_RANDOM   5'd1
`define CP0_REG_WIRED    5'd6
`define CP0_REG_BADVADDR 5'd8
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14
`define CP0_REG_PRID     5'd15 // sel 1 is EBase
`define CP0_REG_CONFIG   5'd16

`define CP0_STATUS_RESET 32'h0040_0000 // BEV only
`define CP0_CONFIG_RESET 32'h0000_8000
`define CP0_PRID_VALUE   32'h0001_8003
`define CP0_EBASE_RESET  32'h8000_0000
`define CP0_BOOT_VECTOR  32'hbfc0_0380 // BEV handler
`define CP0_EXC_OFFSET   32'h0000_0180
`define CP0_TLB_LINES    16 // power of two

`define CP0_IE_BIT  0
`define CP0_EXL_BIT 1
`define CP0_BEV_BIT 22
`define CP0_BD_BIT  31
`define CP0_TI_BIT  30

`endif

// ==== cp0_exc_ctrl.sv ====
`default_nettype none

`include "cp0_defs.svh"

module cp0_exc_ctrl import cp0_pkg::*; (
	input  wire            stall_i,
	input  wire            ri_i,
	input  wire            brk_i,
	input  wire            sys_i,
	input  wire            ov_i,
	input  wire            ades_i,
	input  wire            adel_i,
	input  wire            pc_err_i,
	input  wire            trap_i,
	input  wire            eret_i,
	input  wire cp0_word_t inst_pc_i,
	input  wire            in_delay_i,
	input  wire cp0_word_t alu_addr_i,
	cp0_state_if.sink      st,
	cp0_exc_if.source      exc,
	output logic           flush_o,
	output cp0_word_t      redirect_pc_o,
	output logic           int_pending_o
);

	logic [7:0] ip;
	logic       any_exc;
	exc_code_e  code;

	// timer shares IP7 with hw int 5
	assign ip = {st.cause[15] | st.timer_int, st.cause[14:8]};

	assign int_pending_o = st.status[`CP0_IE_BIT] && !st.status[`CP0_EXL_BIT] &&
		(|(st.status[15:8] & ip));

	always_comb begin
		any_exc = 1'b1;
		code    = EXC_INT;
		if (int_pending_o) code = EXC_INT;
		else if (adel_i || pc_err_i) code = EXC_ADEL;
		else if (ri_i) code = EXC_RI;
		else if (sys_i) code = EXC_SYS;
		else if (brk_i) code = EXC_BP;
		else if (ades_i) code = EXC_ADES;
		else if (ov_i) code = EXC_OV;
		else if (trap_i) code = EXC_TR;
		else any_exc = 1'b0;
	end

	assign exc.exc_valid = !stall_i && any_exc;
	assign exc.eret      = !stall_i && !any_exc && eret_i; // lowest priority
	assign exc.exc_code  = code;
	assign exc.exc_pc    = inst_pc_i;
	assign exc.in_delay  = in_delay_i;
	assign exc.bad_valid = (code == EXC_ADEL) || (code == EXC_ADES);
	assign exc.bad_vaddr = pc_err_i ? inst_pc_i : alu_addr_i; // fetch uses pc

	assign flush_o = exc.exc_valid || exc.eret;

	assign redirect_pc_o = eret_i && !any_exc ? st.epc :
		st.status[`CP0_BEV_BIT] ? `CP0_BOOT_VECTOR :
		st.ebase + `CP0_EXC_OFFSET;

endmodule

`default_nettype wire

// ==== cp0_if.sv ====
`default_nettype none

interface cp0_exc_if import cp0_pkg::*; ();
	logic      exc_valid; // commit on next edge
	exc_code_e exc_code;
	logic      eret;
	cp0_word_t exc_pc;
	logic      in_delay;
	cp0_word_t bad_vaddr;
	logic      bad_valid; // address errors only

	modport source (
		output exc_valid, exc_code, eret, exc_pc, in_delay, bad_vaddr, bad_valid
	);

	modport sink (
		input exc_valid, exc_code, eret, exc_pc, in_delay, bad_vaddr, bad_valid
	);
endinterface

interface cp0_state_if import cp0_pkg::*; ();
	cp0_word_t status;
	cp0_word_t cause; // TI already mirrored
	cp0_word_t epc;
	cp0_word_t ebase;
	logic      timer_int;

	modport regs_source (
		output status, cause, epc, ebase
	);

	modport timer_source (
		output timer_int
	);

	modport sink (
		input status, cause, epc, ebase, timer_int
	);
endinterface

`default_nettype wire

// ==== cp0_pkg.sv ====
`default_nettype none

package cp0_pkg;

	// Cause.ExcCode values
	typedef enum logic [4:0] {
		EXC_INT  = 5'd0,
		EXC_ADEL = 5'd4,  // load or fetch
		EXC_ADES = 5'd5,  // store
		EXC_SYS  = 5'd8,
		EXC_BP   = 5'd9,
		EXC_RI   = 5'd10,
		EXC_OV   = 5'd12,
		EXC_TR   = 5'd13
	} exc_code_e;

	// register number on the mtc0/mfc0 port
	typedef logic [4:0] cp0_addr_t;

	// select field, only EBase uses sel 1
	typedef logic [2:0] cp0_sel_t;

	// register width
	typedef logic [31:0] cp0_word_t;

endpackage

`default_nettype wire

// ==== cp0_regfile.sv ====
`default_nettype none

`include "cp0_defs.svh"

module cp0_regfile import cp0_pkg::*; (
	input  wire            clk,
	input  wire            rst_n_i,
	input  wire            we_i,
	input  wire cp0_addr_t waddr_i,
	input  wire cp0_sel_t  sel_i,
	input  wire cp0_word_t wdata_i,
	input  wire cp0_addr_t raddr_i,
	input  wire cp0_sel_t  rsel_i,
	input  wire            stall_i,
	input  wire [5:0]      int_i,
	input  wire            timer_int_i,
	input  wire cp0_word_t count_i,
	input  wire cp0_word_t compare_i,
	cp0_exc_if.sink        exc,
	cp0_state_if.regs_source st,
	output cp0_word_t      rdata_o
);

	localparam int TLB_W = $clog2(`CP0_TLB_LINES);
	localparam logic [TLB_W-1:0] RAND_TOP = TLB_W'(`CP0_TLB_LINES - 1);

	cp0_word_t        status_q;
	cp0_word_t        cause_q;
	cp0_word_t        epc_q;
	cp0_word_t        badvaddr_q;
	cp0_word_t        ebase_q;
	cp0_word_t        cause_rd;
	logic [TLB_W-1:0] random_q;
	logic [TLB_W-1:0] wired_q;
	logic             wr;

	assign wr = we_i && !stall_i;

	always_comb begin
		cause_rd = cause_q;
		cause_rd[`CP0_TI_BIT] = timer_int_i;
	end

	assign st.status = status_q;
	assign st.cause  = cause_rd;
	assign st.epc    = epc_q;
	assign st.ebase  = ebase_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			status_q <= `CP0_STATUS_RESET;
			cause_q  <= '0;
			ebase_q  <= `CP0_EBASE_RESET;
			random_q <= RAND_TOP;
			wired_q  <= '0;
		end else begin
			random_q <= (random_q == wired_q) ? RAND_TOP : random_q - TLB_W'(1);
			if (!stall_i)
				cause_q[15:10] <= int_i; // hw interrupt lines
			if (wr) begin
				case (waddr_i)
					`CP0_REG_STATUS: status_q <= wdata_i;
					`CP0_REG_CAUSE: begin
						cause_q[9:8] <= wdata_i[9:8]; // sw interrupts
						cause_q[22]  <= wdata_i[22];
						cause_q[23]  <= wdata_i[23];
					end
					`CP0_REG_EPC: epc_q <= wdata_i;
					`CP0_REG_PRID: begin
						if (sel_i == 3'd1)
							ebase_q[29:0] <= wdata_i[29:0];
					end
					`CP0_REG_WIRED: begin
						wired_q  <= wdata_i[TLB_W-1:0];
						random_q <= RAND_TOP;
					end
					default: ;
				endcase
			end
			// commit wins over a same-cycle mtc0
			if (exc.exc_valid) begin
				epc_q <= exc.in_delay ? exc.exc_pc - 32'd4 : exc.exc_pc;
				cause_q[`CP0_BD_BIT] <= exc.in_delay;
				cause_q[6:2] <= exc.exc_code;
				status_q[`CP0_EXL_BIT] <= 1'b1;
				if (exc.bad_valid)
					badvaddr_q <= exc.bad_vaddr;
			end else if (exc.eret) begin
				status_q[`CP0_EXL_BIT] <= 1'b0;
			end
		end
	end

	always_comb begin
		case (raddr_i)
			`CP0_REG_RANDOM:   rdata_o = cp0_word_t'(random_q);
			`CP0_REG_WIRED:    rdata_o = cp0_word_t'(wired_q);
			`CP0_REG_BADVADDR: rdata_o = badvaddr_q;
			`CP0_REG_COUNT:    rdata_o = count_i;
			`CP0_REG_COMPARE:  rdata_o = compare_i;
			`CP0_REG_STATUS:   rdata_o = status_q;
			`CP0_REG_CAUSE:    rdata_o = cause_rd;
			`CP0_REG_EPC:      rdata_o = epc_q;
			`CP0_REG_PRID:     rdata_o = (rsel_i == 3'd1) ? ebase_q : `CP0_PRID_VALUE;
			`CP0_REG_CONFIG:   rdata_o = (rsel_i == 3'd0) ? `CP0_CONFIG_RESET : '0;
			default:           rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== cp0_timer.sv ====
`default_nettype none

`include "cp0_defs.svh"

module cp0_timer import cp0_pkg::*; (
	input  wire            clk,
	input  wire            rst_n_i,
	input  wire            we_i,
	input  wire cp0_addr_t waddr_i,
	input  wire cp0_word_t wdata_i,
	input  wire            stall_i,
	output cp0_word_t      count_o,
	output cp0_word_t      compare_o,
	cp0_state_if.timer_source st
);

	logic [32:0] count_q; // lsb is the half-rate divider
	cp0_word_t   compare_q;
	logic        timer_int_q;
	logic        wr;

	assign wr        = we_i && !stall_i;
	assign count_o   = count_q[32:1];
	assign compare_o = compare_q;
	assign st.timer_int = timer_int_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			count_q     <= '0;
			compare_q   <= '0;
			timer_int_q <= 1'b0;
		end else begin
			count_q <= count_q + 33'd1;
			if (wr && waddr_i == `CP0_REG_COUNT)
				count_q <= {wdata_i, 1'b0};
			if (wr && waddr_i == `CP0_REG_COMPARE) begin
				compare_q   <= wdata_i;
				timer_int_q <= 1'b0; // compare write acks
			end else if (compare_q != '0 && count_o == compare_q) begin
				timer_int_q <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== cp0_unit.f ====
+incdir+.
cp0_pkg.sv
cp0_if.sv
cp0_exc_ctrl.sv
cp0_timer.sv
cp0_regfile.sv
cp0_unit.sv
tb_cp0_unit.sv

// ==== cp0_unit.sv ====
`default_nettype none

module cp0_unit (
	input  wire        clk,
	input  wire        rst_n_i,
	input  wire        we_i,
	input  wire [4:0]  waddr_i,
	input  wire [2:0]  sel_i,
	input  wire [31:0] wdata_i,
	input  wire [4:0]  raddr_i,
	input  wire [2:0]  rsel_i,
	output logic [31:0] rdata_o,
	input  wire        stall_i,
	input  wire [5:0]  int_i,
	input  wire [31:0] inst_pc_i,
	input  wire        in_delay_i,
	input  wire [31:0] alu_addr_i,
	input  wire        ri_i,
	input  wire        brk_i,
	input  wire        sys_i,
	input  wire        ov_i,
	input  wire        ades_i,
	input  wire        adel_i,
	input  wire        pc_err_i,
	input  wire        trap_i,
	input  wire        eret_i,
	output logic       flush_o,
	output logic [31:0] redirect_pc_o,
	output logic       int_pending_o,
	output logic [31:0] count_o
);

	logic [31:0] compare_w;

	cp0_exc_if   exc_if ();
	cp0_state_if st_if ();

	cp0_exc_ctrl u_exc_ctrl (
		.stall_i, .ri_i, .brk_i, .sys_i, .ov_i, .ades_i, .adel_i, .pc_err_i,
		.trap_i, .eret_i, .inst_pc_i, .in_delay_i, .alu_addr_i,
		.st            (st_if),
		.exc           (exc_if),
		.flush_o, .redirect_pc_o, .int_pending_o
	);

	cp0_regfile u_regfile (
		.clk, .rst_n_i, .we_i, .waddr_i, .sel_i, .wdata_i, .raddr_i, .rsel_i,
		.stall_i, .int_i,
		.timer_int_i   (st_if.timer_int),
		.count_i       (count_o),
		.compare_i     (compare_w),
		.exc           (exc_if),
		.st            (st_if),
		.rdata_o
	);

	cp0_timer u_timer (
		.clk, .rst_n_i, .we_i, .waddr_i, .wdata_i, .stall_i, .count_o,
		.compare_o     (compare_w),
		.st            (st_if)
	);

endmodule

`default_nettype wire

// ==== tb_cp0_unit.sv ====
`default_nettype none

`include "cp0_defs.svh"

module tb_cp0_unit import cp0_pkg::*; ();

	localparam int MAX_CYCLES = 4000;
	localparam logic [31:0] RAND_TOP = 32'(`CP0_TLB_LINES - 1);

	logic        clk;
	logic        rst_n_i;
	logic        we_i;
	logic [4:0]  waddr_i;
	logic [2:0]  sel_i;
	logic [31:0] wdata_i;
	logic [4:0]  raddr_i;
	logic [2:0]  rsel_i;
	logic [31:0] rdata_o;
	logic        stall_i;
	logic [5:0]  int_i;
	logic [31:0] inst_pc_i;
	logic        in_delay_i;
	logic [31:0] alu_addr_i;
	logic [7:0]  flags; // ri brk sys ov ades adel pc_err trap
	logic        eret_i;
	logic        flush_o;
	logic [31:0] redirect_pc_o;
	logic        int_pending_o;
	logic [31:0] count_o;

	logic [31:0] rng = 32'haabb1aff;
	logic [31:0] ebase_exp = `CP0_EBASE_RESET;
	int          errors = 0;
	int          tests_pass = 0;
	int          tests_fail = 0;
	int          cycles = 0;

	cp0_unit u_cp0_unit (
		.*,
		.ri_i(flags[7]), .brk_i(flags[6]), .sys_i(flags[5]), .ov_i(flags[4]),
		.ades_i(flags[3]), .adel_i(flags[2]), .pc_err_i(flags[1]), .trap_i(flags[0])
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: no result after %0d cycles", MAX_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// highest ranked code when no interrupt is pending
	function automatic logic [4:0] top_code(input logic [7:0] f);
		if (f[2] || f[1]) return EXC_ADEL;
		if (f[7]) return EXC_RI;
		if (f[5]) return EXC_SYS;
		if (f[6]) return EXC_BP;
		if (f[3]) return EXC_ADES;
		if (f[4]) return EXC_OV;
		return EXC_TR;
	endfunction

	task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("MISMATCH %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int e0);
		if (errors == e0) begin
			tests_pass++;
			$display("%s: ok", name);
		end else begin
			tests_fail++;
			$display("%s: %0d errors", name, errors - e0);
		end
	endtask

	task automatic mtc0(input logic [4:0] addr, input logic [2:0] sel, input logic [31:0] data);
		@(posedge clk);
		we_i    <= 1'b1;
		waddr_i <= addr;
		sel_i   <= sel;
		wdata_i <= data;
		@(posedge clk); // lands here
		we_i    <= 1'b0;
	endtask

	task automatic mfc0(input logic [4:0] addr, input logic [2:0] sel, output logic [31:0] data);
		@(posedge clk);
		raddr_i <= addr;
		rsel_i  <= sel;
		@(negedge clk);
		data = rdata_o;
	endtask

	task automatic reset_state;
		int          e0;
		logic [31:0] d;
		e0 = errors;
		@(negedge clk); // Random not yet moved out of reset
		expect_eq("random", RAND_TOP, rdata_o);
		expect_eq("flush_o", 32'd0, 32'(flush_o));
		expect_eq("int_pending_o", 32'd0, 32'(int_pending_o));
		mfc0(`CP0_REG_STATUS, 3'd0, d);
		expect_eq("status", `CP0_STATUS_RESET, d);
		mfc0(`CP0_REG_CONFIG, 3'd0, d);
		expect_eq("config", `CP0_CONFIG_RESET, d);
		mfc0(`CP0_REG_PRID, 3'd0, d);
		expect_eq("prid", `CP0_PRID_VALUE, d);
		mfc0(`CP0_REG_PRID, 3'd1, d);
		expect_eq("ebase", `CP0_EBASE_RESET, d);
		end_test("reset state", e0);
	endtask

	task automatic register_access;
		int          e0;
		logic [31:0] v;
		logic [31:0] d;
		e0 = errors;
		rng = xorshift(rng);
		v = rng;
		mtc0(`CP0_REG_EPC, 3'd0, v);
		mfc0(`CP0_REG_EPC, 3'd0, d);
		expect_eq("epc", v, d);
		rng = xorshift(rng);
		mtc0(`CP0_REG_COMPARE, 3'd0, rng);
		mfc0(`CP0_REG_COMPARE, 3'd0, d);
		expect_eq("compare", rng, d);
		mtc0(`CP0_REG_COMPARE, 3'd0, 32'h0); // keep the timer quiet
		rng = xorshift(rng);
		mtc0(`CP0_REG_STATUS, 3'd0, rng & 32'hffff_fffe); // IE off
		mfc0(`CP0_REG_STATUS, 3'd0, d);
		expect_eq("status", rng & 32'hffff_fffe, d);
		rng = xorshift(rng);
		mtc0(`CP0_REG_PRID, 3'd1, rng);
		ebase_exp = {2'b10, rng[29:0]};
		mfc0(`CP0_REG_PRID, 3'd1, d);
		expect_eq("ebase", ebase_exp, d);
		rng = xorshift(rng);
		mtc0(`CP0_REG_CAUSE, 3'd0, rng);
		mfc0(`CP0_REG_CAUSE, 3'd0, d);
		expect_eq("cause", rng & 32'h00c0_0300, d);
		mtc0(`CP0_REG_CAUSE, 3'd0, 32'h0);
		// stalled write must not land
		@(posedge clk);
		stall_i <= 1'b1;
		we_i    <= 1'b1;
		waddr_i <= `CP0_REG_EPC;
		wdata_i <= ~v;
		@(posedge clk);
		stall_i <= 1'b0;
		we_i    <= 1'b0;
		mfc0(`CP0_REG_EPC, 3'd0, d);
		expect_eq("epc after stall", v, d);
		end_test("register access", e0);
	endtask

	task automatic exception_priority;
		int          e0;
		logic [7:0]  f;
		logic        dly;
		logic [31:0] pc;
		logic [31:0] alu;
		logic [31:0] exp_redir;
		logic [31:0] d;
		logic [4:0]  code;
		e0 = errors;
		mtc0(`CP0_REG_STATUS, 3'd0, 32'h0040_0000);
		for (int i = 0; i < 8; i++) begin
			if (i == 4) begin // BEV clear from here on
				rng = xorshift(rng);
				mtc0(`CP0_REG_STATUS, 3'd0, 32'h0);
				mtc0(`CP0_REG_PRID, 3'd1, rng & 32'h3fff_f000);
				ebase_exp = {2'b10, rng[29:12], 12'h000};
			end
			rng = xorshift(rng);
			f = (rng[7:0] == 8'h00) ? 8'h01 : rng[7:0];
			dly = rng[8];
			rng = xorshift(rng);
			pc = rng & 32'hffff_fffc;
			rng = xorshift(rng);
			alu = rng;
			code = top_code(f);
			exp_redir = (i < 4) ? `CP0_BOOT_VECTOR : ebase_exp + `CP0_EXC_OFFSET;
			@(posedge clk);
			flags      <= f;
			inst_pc_i  <= pc;
			in_delay_i <= dly;
			alu_addr_i <= alu;
			@(negedge clk);
			expect_eq("flush_o", 32'd1, 32'(flush_o));
			expect_eq("redirect_pc_o", exp_redir, redirect_pc_o);
			@(posedge clk);
			flags      <= 8'h00;
			in_delay_i <= 1'b0;
			mfc0(`CP0_REG_CAUSE, 3'd0, d);
			expect_eq("cause.exccode", 32'(code), 32'(d[6:2]));
			expect_eq("cause.bd", 32'(dly), 32'(d[31]));
			mfc0(`CP0_REG_EPC, 3'd0, d);
			expect_eq("epc", dly ? pc - 32'd4 : pc, d);
			mfc0(`CP0_REG_STATUS, 3'd0, d);
			expect_eq("status.exl", 32'd1, 32'(d[1]));
			if (code == EXC_ADEL || code == EXC_ADES) begin
				mfc0(`CP0_REG_BADVADDR, 3'd0, d);
				expect_eq("badvaddr", f[1] ? pc : alu, d);
			end
		end
		end_test("exception priority", e0);
	endtask

	task automatic eret_return;
		int          e0;
		logic [31:0] ep;
		logic [31:0] d;
		e0 = errors;
		rng = xorshift(rng);
		ep = rng & 32'hffff_fffc;
		mtc0(`CP0_REG_EPC, 3'd0, ep);
		mtc0(`CP0_REG_STATUS, 3'd0, 32'h0000_0002); // EXL set
		@(posedge clk);
		eret_i <= 1'b1;
		@(negedge clk);
		expect_eq("flush_o", 32'd1, 32'(flush_o));
		expect_eq("redirect_pc_o", ep, redirect_pc_o);
		@(posedge clk);
		eret_i <= 1'b0;
		mfc0(`CP0_REG_STATUS, 3'd0, d);
		expect_eq("status.exl", 32'd0, 32'(d[1]));
		end_test("eret", e0);
	endtask

	task automatic interrupt_flush;
		int          e0;
		int          n;
		logic [31:0] d;
		logic [31:0] cnt;
		e0 = errors;
		mtc0(`CP0_REG_STATUS, 3'd0, 32'h0000_0401); // IM2 and IE
		@(posedge clk);
		int_i <= 6'h01;
		@(posedge clk); // sampled into IP2 here
		int_i <= 6'h00;
		@(negedge clk);
		expect_eq("int_pending_o", 32'd1, 32'(int_pending_o));
		expect_eq("flush_o", 32'd1, 32'(flush_o));
		mfc0(`CP0_REG_CAUSE, 3'd0, d);
		expect_eq("cause.exccode", 32'(EXC_INT), 32'(d[6:2]));
		// masked cases
		mtc0(`CP0_REG_STATUS, 3'd0, 32'h0000_0400);
		int_i <= 6'h01;
		repeat (3) begin
			@(negedge clk);
			expect_eq("flush_o ie clear", 32'd0, 32'(flush_o));
		end
		mtc0(`CP0_REG_STATUS, 3'd0, 32'h0000_0001);
		repeat (3) begin
			@(negedge clk);
			expect_eq("flush_o im clear", 32'd0, 32'(flush_o));
		end
		@(posedge clk);
		int_i <= 6'h00;
		// timer through IP7
		mtc0(`CP0_REG_STATUS, 3'd0, 32'h0000_8001);
		rng = xorshift(rng);
		cnt = rng & 32'h0fff_ffff;
		mtc0(`CP0_REG_COUNT, 3'd0, cnt);
		@(negedge clk);
		expect_eq("count_o", cnt, count_o);
		mtc0(`CP0_REG_COMPARE, 3'd0, cnt + 32'd3);
		raddr_i <= `CP0_REG_CAUSE;
		rsel_i  <= 3'd0;
		n = 0;
		@(negedge clk);
		expect_eq("count_o", cnt + 32'd1, count_o); // two edges, one step
		while (rdata_o[30] !== 1'b1 && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (rdata_o[30] !== 1'b1) begin
			$display("timer interrupt did not show in Cause within 20 cycles");
			errors++;
		end else begin
			expect_eq("int_pending_o timer", 32'd1, 32'(int_pending_o));
		end
		mtc0(`CP0_REG_COMPARE, 3'd0, 32'h0);
		mfc0(`CP0_REG_CAUSE, 3'd0, d);
		expect_eq("cause.ti", 32'd0, 32'(d[30]));
		end_test("interrupts", e0);
	endtask

	task automatic random_wired;
		int          e0;
		logic [31:0] w;
		logic [31:0] exp;
		e0 = errors;
		mtc0(`CP0_REG_STATUS, 3'd0, 32'h0);
		rng = xorshift(rng);
		w = rng & 32'h0000_0007;
		mtc0(`CP0_REG_WIRED, 3'd0, w);
		raddr_i <= `CP0_REG_RANDOM;
		rsel_i  <= 3'd0;
		exp = RAND_TOP;
		repeat (24) begin
			@(negedge clk);
			expect_eq("random", exp, rdata_o);
			exp = (exp == w) ? RAND_TOP : exp - 32'd1;
		end
		end_test("random and wired", e0);
	endtask

	initial begin
		rst_n_i    <= 1'b0;
		we_i       <= 1'b0;
		waddr_i    <= '0;
		sel_i      <= '0;
		wdata_i    <= '0;
		raddr_i    <= `CP0_REG_RANDOM;
		rsel_i     <= '0;
		stall_i    <= 1'b0;
		int_i      <= '0;
		inst_pc_i  <= '0;
		in_delay_i <= 1'b0;
		alu_addr_i <= '0;
		flags      <= '0;
		eret_i     <= 1'b0;
		repeat (5) @(posedge clk);
		rst_n_i <= 1'b1;
		reset_state();
		register_access();
		exception_priority();
		eret_return();
		interrupt_flush();
		random_wired();
		$display("tests passed %0d, failed %0d", tests_pass, tests_fail);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
